//--- common/c16_bus_pkg.sv
package c16_bus_pkg;

	////////////////////////////////////////////////////////////
	// CPU bus widths
	////////////////////////////////////////////////////////////

	localparam int ADDR_W     = 16;
	localparam int DATA_W     = 8;
	// One 16 KB ROM image
	localparam int ROM_ADDR_W = 14;

	typedef logic [ADDR_W-1:0]     addr_t;
	typedef logic [DATA_W-1:0]     data_t;
	typedef logic [ROM_ADDR_W-1:0] rom_addr_t;

	// Bus as seen from the memory side, chip selects are active low
	typedef struct packed {
		addr_t addr;
		data_t dout;
		logic  rnw;
		logic  cs_ram;
		logic  cs0;
		logic  cs1;
		logic  cs_io;
	} cpu_bus_t;

	////////////////////////////////////////////////////////////
	// Plus/4 banking
	////////////////////////////////////////////////////////////

	// Code 3 is unused by the stock machine and selects nothing
	typedef enum logic [1:0] {
		BANK_INTERNAL = 2'd0,
		BANK_CART     = 2'd1,
		BANK_FUNC     = 2'd2
	} bank_t;

	// Kernal stays visible in this page whatever the high bank holds
	localparam logic [7:0]  KERNAL_PAGE  = 8'hFC;
	// Bank register lives at FDD0..FDDF, the low nibble is the data
	localparam logic [11:0] BANK_IO_PAGE = 12'hFDD;

	// Undriven data bus, every source ANDs into it
	localparam data_t BUS_IDLE = '1;

endpackage

//--- common/c16_load_pkg.sv
package c16_load_pkg;

	////////////////////////////////////////////////////////////
	// Host download port
	////////////////////////////////////////////////////////////

	typedef struct packed {
		logic        download;
		logic [7:0]  index;
		logic        wr;
		logic [24:0] addr;
		logic [7:0]  dout;
	} load_port_t;

	// File types sent by the host
	localparam logic [7:0] IDX_PRG = 8'h01;
	localparam logic [7:0] IDX_ROM = 8'h03;
	localparam logic [7:0] IDX_CRT = 8'h81;

	// Download address bits above the 16 KB image offset
	localparam int SLOT_W = 11;

	// Image order inside the combined ROM file
	localparam logic [SLOT_W-1:0] ROM_SLOT_KERNAL  = 11'd1;
	localparam logic [SLOT_W-1:0] ROM_SLOT_BASIC   = 11'd2;
	localparam logic [SLOT_W-1:0] ROM_SLOT_FUNC_LO = 11'd3;
	localparam logic [SLOT_W-1:0] ROM_SLOT_FUNC_HI = 11'd4;

	localparam logic [SLOT_W-1:0] CRT_SLOT_LO = 11'd0;
	localparam logic [SLOT_W-1:0] CRT_SLOT_HI = 11'd1;

	// Bit positions of the ROM stores in the enable vectors
	localparam int IMG_KERNAL  = 0;
	localparam int IMG_BASIC   = 1;
	localparam int IMG_FUNC_LO = 2;
	localparam int IMG_FUNC_HI = 3;
	localparam int IMG_CART_LO = 4;
	localparam int IMG_CART_HI = 5;
	localparam int IMG_COUNT   = 6;

	// BASIC start-of-variables and end-of-program pointers, entry 0 first
	localparam logic [7:0][15:0] FIXUP_ADDRS = {
		16'h009E, 16'h009D, 16'h0032, 16'h0031,
		16'h0030, 16'h002F, 16'h002E, 16'h002D
	};

endpackage

//--- src/byte_store.sv
`timescale 1ns/1ps

module byte_store #(
	parameter int ADDR_W = 14
) (
	input  logic                  clk_sys,
	input  logic [ADDR_W-1:0]     wr_addr_i,
	input  c16_bus_pkg::data_t    wr_data_i,
	input  logic                  wr_en_i,
	input  logic [ADDR_W-1:0]     rd_addr_i,
	input  c16_bus_pkg::data_t    rd_data_i,
	input  logic                  rd_we_i,
	input  logic                  rd_en_i,
	output c16_bus_pkg::data_t    q_o
);

	localparam int DEPTH = 1 << ADDR_W;

	c16_bus_pkg::data_t mem [DEPTH];

	// Images start out blank until the host sends them
	initial begin
		for (int i = 0; i < DEPTH; i++) begin
			mem[i] = '0;
		end
	end

	////////////////////////////////////////////////////////////
	// Both ports in one process, the CPU port wins a collision
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (wr_en_i) begin
			mem[wr_addr_i] <= wr_data_i;
		end
		if (rd_we_i) begin
			mem[rd_addr_i] <= rd_data_i;
		end

		// Deselected store floats high on the shared bus
		if (rd_en_i) begin
			q_o <= mem[rd_addr_i];
		end else begin
			q_o <= c16_bus_pkg::BUS_IDLE;
		end
	end

endmodule

//--- loader/prg_loader.sv
`timescale 1ns/1ps

module prg_loader (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  c16_load_pkg::load_port_t load_i,
	output c16_bus_pkg::addr_t       ld_addr_o,
	output c16_bus_pkg::data_t       ld_data_o,
	output logic                     ld_we_o
);

	logic               is_prg;
	logic               prg_wr;
	logic               hdr_lo;
	logic               hdr_hi;
	logic               data_wr;
	logic               fix_wr;
	logic               dl_end;
	logic               download_q;
	logic [3:0]         fix_cnt;
	c16_bus_pkg::addr_t next_addr;

	assign is_prg = (load_i.index == c16_load_pkg::IDX_PRG);
	assign prg_wr = load_i.download && is_prg && load_i.wr;

	// First two file bytes are the little-endian load address
	assign hdr_lo  = prg_wr && (load_i.addr == 25'd0);
	assign hdr_hi  = prg_wr && (load_i.addr == 25'd1);
	assign data_wr = prg_wr && (|load_i.addr[24:1]);

	assign dl_end = download_q && !load_i.download && is_prg;

	// Pointer writes land on the odd counts of the sequence
	assign fix_wr = fix_cnt[0];

	////////////////////////////////////////////////////////////
	// Sequencer
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			download_q <= 1'b0;
			fix_cnt    <= '0;
			ld_we_o    <= 1'b0;
		end else begin
			download_q <= load_i.download;
			ld_we_o    <= data_wr || fix_wr;

			if (load_i.download && is_prg) begin
				fix_cnt <= '0;
			end else if (dl_end) begin
				fix_cnt <= 4'd1;
			end else if (fix_cnt != '0) begin
				// Wraps back to zero after count 15
				fix_cnt <= fix_cnt + 4'd1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Address and data path
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (hdr_lo) begin
			next_addr[7:0] <= load_i.dout;
		end
		if (hdr_hi) begin
			next_addr[15:8] <= load_i.dout;
		end

		if (data_wr) begin
			ld_addr_o <= next_addr;
			ld_data_o <= load_i.dout;
			next_addr <= next_addr + 16'd1;
		end else if (fix_wr) begin
			// next_addr now holds the end of the program
			ld_addr_o <= c16_load_pkg::FIXUP_ADDRS[fix_cnt[3:1]];
			ld_data_o <= fix_cnt[1] ? next_addr[15:8] : next_addr[7:0];
		end
	end

endmodule

//--- src/bus_ctrl.sv
`timescale 1ns/1ps

module bus_ctrl (
	input  logic                                  clk_sys,
	input  logic                                  reset,
	input  logic                                  model_i,
	input  c16_load_pkg::load_port_t              load_i,
	input  c16_bus_pkg::cpu_bus_t                 bus_i,
	output logic                                  ram_re_o,
	output logic                                  ram_we_o,
	output logic [c16_load_pkg::IMG_COUNT-1:0]    rom_re_o,
	output logic [c16_load_pkg::IMG_COUNT-1:0]    rom_we_o,
	output logic                                  rom_loaded_o
);

	logic                            model_q;
	c16_bus_pkg::bank_t              bank_lo;
	c16_bus_pkg::bank_t              bank_hi;
	logic                            cart_lo_q;
	logic                            cart_hi_q;
	// ROM images survive a reset, and so does this flag
	logic                            rom_loaded_q = 1'b0;
	logic                            cs_ram_q;
	logic                            cs_io_q;
	logic                            kern_page;
	logic                            bank_hit;
	logic                            ld_rom;
	logic                            ld_crt;
	logic [c16_load_pkg::SLOT_W-1:0] slot;

	assign kern_page = (bus_i.addr[15:8] == c16_bus_pkg::KERNAL_PAGE);
	assign bank_hit  = (bus_i.addr[15:4] == c16_bus_pkg::BANK_IO_PAGE);

	////////////////////////////////////////////////////////////
	// Read enables
	////////////////////////////////////////////////////////////

	always_comb begin
		ram_re_o = !bus_i.cs_ram;

		rom_re_o[c16_load_pkg::IMG_BASIC]   = !bus_i.cs0 &&
			(bank_lo == c16_bus_pkg::BANK_INTERNAL);
		rom_re_o[c16_load_pkg::IMG_FUNC_LO] = !bus_i.cs0 &&
			(bank_lo == c16_bus_pkg::BANK_FUNC);
		rom_re_o[c16_load_pkg::IMG_CART_LO] = !bus_i.cs0 &&
			(bank_lo == c16_bus_pkg::BANK_CART) && cart_lo_q;

		rom_re_o[c16_load_pkg::IMG_KERNAL]  = !bus_i.cs1 &&
			((bank_hi == c16_bus_pkg::BANK_INTERNAL) || kern_page);
		rom_re_o[c16_load_pkg::IMG_FUNC_HI] = !bus_i.cs1 && !kern_page &&
			(bank_hi == c16_bus_pkg::BANK_FUNC);
		rom_re_o[c16_load_pkg::IMG_CART_HI] = !bus_i.cs1 && !kern_page &&
			(bank_hi == c16_bus_pkg::BANK_CART) && cart_hi_q;
	end

	////////////////////////////////////////////////////////////
	// Download write enables
	////////////////////////////////////////////////////////////

	assign slot   = load_i.addr[c16_bus_pkg::ROM_ADDR_W +: c16_load_pkg::SLOT_W];
	assign ld_rom = load_i.wr && (load_i.index == c16_load_pkg::IDX_ROM);
	assign ld_crt = load_i.wr && (load_i.index == c16_load_pkg::IDX_CRT);

	always_comb begin
		rom_we_o[c16_load_pkg::IMG_KERNAL]  = ld_rom && (slot == c16_load_pkg::ROM_SLOT_KERNAL);
		rom_we_o[c16_load_pkg::IMG_BASIC]   = ld_rom && (slot == c16_load_pkg::ROM_SLOT_BASIC);
		rom_we_o[c16_load_pkg::IMG_FUNC_LO] = ld_rom && (slot == c16_load_pkg::ROM_SLOT_FUNC_LO);
		rom_we_o[c16_load_pkg::IMG_FUNC_HI] = ld_rom && (slot == c16_load_pkg::ROM_SLOT_FUNC_HI);
		rom_we_o[c16_load_pkg::IMG_CART_LO] = ld_crt && (slot == c16_load_pkg::CRT_SLOT_LO);
		rom_we_o[c16_load_pkg::IMG_CART_HI] = ld_crt && (slot == c16_load_pkg::CRT_SLOT_HI);
	end

	assign rom_loaded_o = rom_loaded_q;

	always_ff @(posedge clk_sys) begin
		if (rom_we_o[c16_load_pkg::IMG_KERNAL]) begin
			rom_loaded_q <= 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// Model latch, banks, cart flags and CPU write strobe
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		cs_ram_q <= bus_i.cs_ram;
		cs_io_q  <= bus_i.cs_io;

		if (reset) begin
			model_q   <= model_i;
			bank_lo   <= c16_bus_pkg::BANK_INTERNAL;
			bank_hi   <= c16_bus_pkg::BANK_INTERNAL;
			cart_lo_q <= 1'b0;
			cart_hi_q <= 1'b0;
			ram_we_o  <= 1'b0;
		end else begin
			// Write goes out on the cycle after cs_ram is released
			ram_we_o <= !cs_ram_q && bus_i.cs_ram && !bus_i.rnw;

			// Banking only exists on the Plus/4
			if (model_q && !cs_io_q && bus_i.cs_io && !bus_i.rnw && bank_hit) begin
				bank_lo <= c16_bus_pkg::bank_t'(bus_i.addr[1:0]);
				bank_hi <= c16_bus_pkg::bank_t'(bus_i.addr[3:2]);
			end

			if (rom_we_o[c16_load_pkg::IMG_CART_LO]) begin
				cart_lo_q <= 1'b1;
			end
			if (rom_we_o[c16_load_pkg::IMG_CART_HI]) begin
				cart_hi_q <= 1'b1;
			end
		end
	end

endmodule

//--- src/c16_mem_top.sv
`timescale 1ns/1ps

module c16_mem_top (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  logic                     model_i,
	input  c16_load_pkg::load_port_t load_i,
	input  c16_bus_pkg::cpu_bus_t    bus_i,
	output c16_bus_pkg::data_t       din_o,
	output logic                     rom_loaded_o
);

	logic                                  ram_re;
	logic                                  ram_we;
	logic [c16_load_pkg::IMG_COUNT-1:0]    rom_re;
	logic [c16_load_pkg::IMG_COUNT-1:0]    rom_we;
	c16_bus_pkg::addr_t                    ld_addr;
	c16_bus_pkg::data_t                    ld_data;
	logic                                  ld_we;
	c16_bus_pkg::data_t                    ram_q;
	c16_bus_pkg::data_t                    rom_q [c16_load_pkg::IMG_COUNT];

	bus_ctrl u_bus_ctrl (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.model_i      (model_i),
		.load_i       (load_i),
		.bus_i        (bus_i),
		.ram_re_o     (ram_re),
		.ram_we_o     (ram_we),
		.rom_re_o     (rom_re),
		.rom_we_o     (rom_we),
		.rom_loaded_o (rom_loaded_o)
	);

	prg_loader u_prg_loader (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.load_i    (load_i),
		.ld_addr_o (ld_addr),
		.ld_data_o (ld_data),
		.ld_we_o   (ld_we)
	);

	// Loader on port A, CPU on port B
	byte_store #(.ADDR_W(c16_bus_pkg::ADDR_W)) main_ram (
		.clk_sys   (clk_sys),
		.wr_addr_i (ld_addr),
		.wr_data_i (ld_data),
		.wr_en_i   (ld_we),
		.rd_addr_i (bus_i.addr),
		.rd_data_i (bus_i.dout),
		.rd_we_i   (ram_we),
		.rd_en_i   (ram_re),
		.q_o       (ram_q)
	);

	// Kernal, basic, function low/high, cart low/high in IMG_* order
	for (genvar i = 0; i < c16_load_pkg::IMG_COUNT; i++) begin : g_rom
		byte_store #(.ADDR_W(c16_bus_pkg::ROM_ADDR_W)) u_rom (
			.clk_sys   (clk_sys),
			.wr_addr_i (load_i.addr[c16_bus_pkg::ROM_ADDR_W-1:0]),
			.wr_data_i (load_i.dout),
			.wr_en_i   (rom_we[i]),
			.rd_addr_i (bus_i.addr[c16_bus_pkg::ROM_ADDR_W-1:0]),
			.rd_data_i (bus_i.dout),
			.rd_we_i   (1'b0),
			.rd_en_i   (rom_re[i]),
			.q_o       (rom_q[i])
		);
	end

	always_comb begin
		din_o = ram_q;
		for (int i = 0; i < c16_load_pkg::IMG_COUNT; i++) begin
			din_o = din_o & rom_q[i];
		end
	end

endmodule

//--- test/tb_c16_mem.sv
`timescale 1ns/1ps

module tb_c16_mem;

	typedef struct packed {
		logic [7:0]  op;
		logic [7:0]  sel;
		logic [7:0]  index;
		logic [24:0] addr;
		logic [7:0]  data;
		logic        use_model;
	} vec_t;

	logic                     clk_sys = 1'b0;
	logic                     reset;
	logic                     model;
	c16_load_pkg::load_port_t load;
	c16_bus_pkg::cpu_bus_t    bus;
	c16_bus_pkg::data_t       din;
	logic                     rom_loaded;

	vec_t        vecs [$];
	logic [7:0]  ram_model [65536];
	logic [15:0] prg_addr;
	int          errors = 0;
	int unsigned vec_cycles = 0;
	int unsigned limit = 32'hFFFF_FFFF;
	int unsigned cycles = 0;

	c16_mem_top uut (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.model_i      (model),
		.load_i       (load),
		.bus_i        (bus),
		.din_o        (din),
		.rom_loaded_o (rom_loaded)
	);

	always #10 clk_sys = ~clk_sys;

	function automatic c16_bus_pkg::cpu_bus_t idle_bus();
		c16_bus_pkg::cpu_bus_t b;
		b = '1;
		b.addr = '0;
		b.dout = '0;
		return b;
	endfunction

	// Value of a hex token read with %s
	function automatic logic [31:0] hex_value(input logic [63:0] tok);
		logic [31:0] val;
		logic [7:0]  c;
		val = '0;
		for (int i = 7; i >= 0; i--) begin
			c = tok[8*i +: 8];
			if (c >= "0" && c <= "9") begin
				val = {val[27:0], 4'(c - "0")};
			end else if (c >= "A" && c <= "F") begin
				val = {val[27:0], 4'(c - "A" + 8'd10)};
			end else if (c >= "a" && c <= "f") begin
				val = {val[27:0], 4'(c - "a" + 8'd10)};
			end
		end
		return val;
	endfunction

	// Every operation starts 2 ns after a rising edge
	task automatic step(input int n);
		repeat (n) begin
			@(posedge clk_sys);
			#2;
		end
	endtask

	task automatic check_byte(input logic [15:0] addr, input logic [7:0] exp,
		input logic [7:0] act);
		assert (act === exp) else begin
			$display("[ERROR] %0t addr %h expected %h got %h", $time, addr, exp, act);
			errors++;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Vector file parser
	////////////////////////////////////////////////////////////

	task automatic read_vectors();
		int              fd;
		int              n;
		logic [63:0]     tok;
		logic [63:0]     arg;
		logic [2047:0]   rest;
		logic [31:0]     a;
		logic [31:0]     b;
		vec_t            v;
		fd = $fopen("test/c16_mem_vectors.txt", "r");
		if (fd == 0) begin
			$display("Could not open the vector file test/c16_mem_vectors.txt");
			errors++;
			return;
		end
		while ($fscanf(fd, "%s", tok) == 1) begin
			v = '0;
			v.op = tok[7:0];
			a = '0;
			b = '0;
			case (tok[7:0])
				"#": n = $fgets(rest, fd);
				"M", "F", "I", "B": n = $fscanf(fd, "%h", a);
				"L": begin
					n = $fscanf(fd, "%h %h %s", b, a, arg);
					v.index = b[7:0];
					if (arg == "R") begin
						v.data = 8'($urandom);
					end else begin
						b = hex_value(arg);
						v.data = b[7:0];
					end
				end
				"R": begin
					n = $fscanf(fd, "%s %h %s", tok, a, arg);
					v.sel = tok[7:0];
					v.use_model = (arg == "M");
					b = hex_value(arg);
					v.data = b[7:0];
				end
				"W": begin
					n = $fscanf(fd, "%h %h", a, b);
					v.data = b[7:0];
				end
				"T", "E": ;
				default: begin
					$display("Unknown opcode in the vector file");
					errors++;
				end
			endcase
			v.addr = a[24:0];
			// Nominal length of each operation in clock cycles
			case (v.op)
				"L", "R", "B": vec_cycles += 2;
				"W", "T": vec_cycles += 3;
				"E": vec_cycles += 1;
				"I": vec_cycles += a;
				default: ;
			endcase
			if (v.op != "#") begin
				vecs.push_back(v);
			end
		end
		$fclose(fd);
	endtask

	////////////////////////////////////////////////////////////
	// Expected RAM contents
	////////////////////////////////////////////////////////////

	// Header bytes set the address, the rest land in order
	task automatic track_prg(input vec_t v);
		if (v.addr == 25'd0) begin
			prg_addr[7:0] = v.data;
		end else if (v.addr == 25'd1) begin
			prg_addr[15:8] = v.data;
		end else begin
			ram_model[prg_addr] = v.data;
			prg_addr = prg_addr + 16'd1;
		end
	endtask

	// Even pointer entries take the low end byte, odd ones the high byte
	task automatic track_fixups();
		for (int k = 0; k < 8; k++) begin
			if (k % 2 == 1) begin
				ram_model[c16_load_pkg::FIXUP_ADDRS[k]] = prg_addr[15:8];
			end else begin
				ram_model[c16_load_pkg::FIXUP_ADDRS[k]] = prg_addr[7:0];
			end
		end
	endtask

	////////////////////////////////////////////////////////////
	// Bus operations
	////////////////////////////////////////////////////////////

	task automatic cpu_read(input vec_t v);
		logic [7:0] exp;
		exp = v.use_model ? ram_model[v.addr[15:0]] : v.data;
		bus.addr = v.addr[15:0];
		case (v.sel)
			"r": bus.cs_ram = 1'b0;
			"0": bus.cs0 = 1'b0;
			"1": bus.cs1 = 1'b0;
			default: ;
		endcase
		// Data is registered on the edge after the select
		@(posedge clk_sys);
		#1;
		check_byte(v.addr[15:0], exp, din);
		#1;
		bus = idle_bus();
		step(1);
	endtask

	task automatic cpu_write(input vec_t v);
		bus.addr = v.addr[15:0];
		bus.dout = v.data;
		bus.rnw = 1'b0;
		bus.cs_ram = 1'b0;
		step(1);
		// Address and data held two cycles past the release
		bus.cs_ram = 1'b1;
		step(2);
		bus = idle_bus();
		ram_model[v.addr[15:0]] = v.data;
	endtask

	task automatic bank_write(input vec_t v);
		bus.addr = v.addr[15:0];
		bus.rnw = 1'b0;
		bus.cs_io = 1'b0;
		step(1);
		bus.cs_io = 1'b1;
		step(1);
		bus = idle_bus();
	endtask

	task automatic run_vector(input vec_t v);
		case (v.op)
			"M": model = v.addr[0];
			"T": begin
				reset = 1'b1;
				step(3);
				reset = 1'b0;
			end
			"L": begin
				load.download = 1'b1;
				load.index = v.index;
				load.addr = v.addr;
				load.dout = v.data;
				load.wr = 1'b1;
				if (v.index == c16_load_pkg::IDX_PRG) begin
					track_prg(v);
				end
				step(1);
				load.wr = 1'b0;
				step(1);
			end
			"E": begin
				load.download = 1'b0;
				if (load.index == c16_load_pkg::IDX_PRG) begin
					track_fixups();
				end
				step(1);
			end
			"R": cpu_read(v);
			"W": cpu_write(v);
			"B": bank_write(v);
			"I": step(int'(v.addr));
			"F": begin
				assert (rom_loaded === v.addr[0]) else begin
					$display("[ERROR] %0t rom_loaded_o expected %b got %b",
						$time, v.addr[0], rom_loaded);
					errors++;
				end
			end
			default: ;
		endcase
	endtask

	initial begin
		void'($urandom(32'h660becb3));
		model = 1'b0;
		reset = 1'b1;
		load = '0;
		bus = idle_bus();
		prg_addr = '0;
		for (int i = 0; i < 65536; i++) begin
			ram_model[i] = 8'h00;
		end
		read_vectors();
		limit = 4 * vec_cycles + 200;
		step(3);
		reset = 1'b0;
		foreach (vecs[i]) begin
			run_vector(vecs[i]);
		end
		step(2);
		$display("Ran %0d vectors with %0d errors", vecs.size(), errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

	// Watchdog
	initial begin
		while (cycles < limit) begin
			@(posedge clk_sys);
			cycles++;
		end
		$display("Timeout: the run did not finish within %0d cycles, %0d errors so far",
			limit, errors);
		$display("Checks failed");
		$finish;
	end

endmodule

//--- test/c16_mem_vectors.txt
# Columns: opcode, then hex arguments. M model, T reset, E end download, F rom_loaded
# L index addr data (R draws a random byte), W addr data, B addr, I idle cycles
# R select addr expect, select r/0/1/n, expect M takes the RAM model
M 1
T
F 0
# ROM images: kernal, kernal page, basic, function low
L 03 4010 A5
L 03 7C10 3C
F 1
L 03 8020 5B
L 03 C020 F1
E
R 0 8020 5B
R 1 C010 A5
R n 1234 FF
# PRG at 1000 with three data bytes
L 01 0 00
L 01 1 10
L 01 2 R
L 01 3 R
L 01 4 R
E
I 20
R r 1000 M
R r 1001 M
R r 1002 M
R r 002D M
R r 002E M
R r 002F M
R r 0030 M
R r 0031 M
R r 0032 M
R r 009D M
R r 009E M
W 2000 C3
R r 2000 M
# Plus/4 banking, low bank FUNC and high bank CART
B FDD6
R 0 8020 F1
R 1 C030 FF
L 81 4030 7E
E
R 1 C030 7E
R 1 FC10 3C
# C16 ignores the bank register
M 0
T
B FDD6
R 0 8020 5B
R 1 C010 A5
# Reset brings both banks back to internal
M 1
T
B FDD6
R 0 8020 F1
T
R 0 8020 5B
R 1 C010 A5

//--- sim.f
common/c16_bus_pkg.sv
common/c16_load_pkg.sv
src/byte_store.sv
loader/prg_loader.sv
src/bus_ctrl.sv
src/c16_mem_top.sv
test/tb_c16_mem.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_c16_mem
RTL_TOP   ?= c16_mem_top
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
PASS_MSG  ?= All checks passed
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing --assert -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)
